//--- design/cache_config.svh
// Cache subsystem geometry
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ====================
// word and access size
// ====================
`define DATA_BITS 32
// byte, half, word
`define CACHE_TYPE_BITS 2

// ====================
// cache geometry
// ====================
// direct mapped, 32 lines of 16 bytes
`define CACHE_LINES 32
`define CACHE_INDEX_BITS 5
// byte offset inside a line
`define CACHE_OFFSET_BITS 4
// 32 - index - offset
`define CACHE_TAG_BITS 23
// one line is four words
`define CACHE_DATA_BITS 128
// one enable per byte of a line
`define CACHE_WRITE_BITS 16

// ====================
// main memory
// ====================
// word depth, higher addresses wrap
`define MEM_WORDS 1024
// wait cycles ahead of the done cycle
`define MEM_LATENCY 3

`endif

//--- design/cache_pkg.sv
// Cache subsystem types
`include "cache_config.svh"

package cache_pkg;

  // ====================
  // address word
  // ====================
  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]    tag;
    logic [`CACHE_INDEX_BITS-1:0]  index;
    logic [`CACHE_OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  // same word, raw byte address or tag/index/offset
  typedef union packed {
    logic [`DATA_BITS-1:0] raw;
    addr_fields_t          f;
  } cache_addr_u;

  typedef enum logic [`CACHE_TYPE_BITS-1:0] {
    ACC_BYTE = 2'd0,
    ACC_HALF = 2'd1,
    ACC_WORD = 2'd2
  } access_type_e;

  // ====================
  // port bundles
  // ====================
  // 1 + 1 + 32 + 32 + 2 bits
  typedef struct packed {
    logic                  req;
    logic                  write;
    cache_addr_u           addr;
    logic [`DATA_BITS-1:0] wdata;
    access_type_e          acc_type;
  } core_req_t;

  // stall is the wait level, high until the done cycle
  typedef struct packed {
    logic [`DATA_BITS-1:0] rdata;
    logic                  stall;
  } core_rsp_t;

  // memory bus, same layout as the core side
  typedef struct packed {
    logic                  req;
    logic                  write;
    cache_addr_u           addr;
    logic [`DATA_BITS-1:0] wdata;
    access_type_e          acc_type;
  } mem_req_t;

  typedef struct packed {
    logic [`DATA_BITS-1:0] rdata;
    logic                  stall;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    FILL,
    DELIVER,
    WRITE
  } ctrl_state_e;

  // byte lanes touched by a store at this offset
  function automatic logic [3:0] byte_mask(access_type_e t, logic [1:0] off);
    logic [3:0] m;
    case (t)
      ACC_BYTE: m = 4'b0001 << off;
      ACC_HALF: m = 4'b0011 << {off[1], 1'b0};
      default:  m = 4'b1111;
    endcase
    return m;
  endfunction

  // store data copied into every lane, mask picks the live one
  function automatic logic [`DATA_BITS-1:0] lane_data(logic [`DATA_BITS-1:0] d,
                                                      access_type_e t);
    logic [`DATA_BITS-1:0] r;
    case (t)
      ACC_BYTE: r = {4{d[7:0]}};
      ACC_HALF: r = {2{d[15:0]}};
      default:  r = d;
    endcase
    return r;
  endfunction

endpackage

//--- design/tag_array.sv
// Cache tag RAM
`include "cache_config.svh"

module tag_array (
  input  logic                         clk,
  input  logic [`CACHE_INDEX_BITS-1:0] addr,
  input  logic [`CACHE_TAG_BITS-1:0]   wdata,
  input  logic                         we,
  output logic [`CACHE_TAG_BITS-1:0]   rdata
);

  // one tag per line
  logic [`CACHE_TAG_BITS-1:0] mem [`CACHE_LINES];

  // ====================
  // write and read port
  // ====================
  // registered read
  // a write in the same cycle shows up on rdata next cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

//--- design/data_array.sv
// Cache line RAM
`include "cache_config.svh"

module data_array (
  input  logic                         clk,
  input  logic [`CACHE_INDEX_BITS-1:0] addr,
  input  logic [`CACHE_DATA_BITS-1:0]  wdata,
  input  logic [`CACHE_WRITE_BITS-1:0] byte_we,
  output logic [`CACHE_DATA_BITS-1:0]  rdata
);

  // one 16-byte line per entry
  logic [`CACHE_DATA_BITS-1:0] mem [`CACHE_LINES];

  // ====================
  // byte-masked port
  // ====================
  // fills write one word, stores write one to four bytes
  // unmasked bytes read back the stored line
  always_ff @(posedge clk) begin
    for (int b = 0; b < `CACHE_WRITE_BITS; b++) begin
      if (byte_we[b]) begin
        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
        // write-first per byte
        rdata[b*8 +: 8]     <= wdata[b*8 +: 8];
      end else begin
        rdata[b*8 +: 8] <= mem[addr][b*8 +: 8];
      end
    end
  end

endmodule

//--- design/l1c_inst.sv
// L1 instruction cache controller
`include "cache_config.svh"

module l1c_inst (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cache_pkg::core_req_t core_req,
  output cache_pkg::core_rsp_t core_rsp,
  output cache_pkg::mem_req_t  mem_req,
  input  cache_pkg::mem_rsp_t  mem_rsp
);
  import cache_pkg::*;

  // word select inside a line
  localparam int WORD_SEL_BITS = `CACHE_OFFSET_BITS - 2;
  localparam int LINE_WORDS = `CACHE_DATA_BITS / `DATA_BITS;

  ctrl_state_e                  state, state_nx;
  logic [`CACHE_LINES-1:0]      valid;
  logic [WORD_SEL_BITS-1:0]     fill_cnt;
  logic [`DATA_BITS-1:0]        fill_word;
  logic [`CACHE_INDEX_BITS-1:0] index;
  logic [WORD_SEL_BITS-1:0]     word_sel;
  logic [`CACHE_TAG_BITS-1:0]   tag_rdata;
  logic                         tag_we;
  logic [`CACHE_DATA_BITS-1:0]  da_rdata;
  logic [`CACHE_DATA_BITS-1:0]  da_wdata;
  logic [`CACHE_WRITE_BITS-1:0] da_byte_we;
  logic                         hit;
  logic                         fill_step;

  // request is held stable while stalled, so decode it directly
  assign index    = core_req.addr.f.index;
  assign word_sel = core_req.addr.f.offset[`CACHE_OFFSET_BITS-1:2];

  // tag and valid compare, arrays were read in the previous cycle
  assign hit = valid[index] && (tag_rdata == core_req.addr.f.tag);

  // one refill word accepted by memory
  assign fill_step = (state == FILL) && !mem_rsp.stall;

  // ====================
  // arrays
  // ====================
  tag_array tag_array_i (
    .clk  (clk),
    .addr (index),
    .wdata(core_req.addr.f.tag),
    .we   (tag_we),
    .rdata(tag_rdata)
  );

  data_array data_array_i (
    .clk    (clk),
    .addr   (index),
    .wdata  (da_wdata),
    .byte_we(da_byte_we),
    .rdata  (da_rdata)
  );

  // ====================
  // control state
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      fill_cnt <= '0;
      valid    <= '0;
    end else begin
      state <= state_nx;
      if (fill_step) begin
        // wraps back to zero after the last word
        fill_cnt <= fill_cnt + 1'b1;
        if (fill_cnt == '1) begin
          valid[index] <= 1'b1;
        end
      end
    end
  end

  // keep the word the core asked for
  always_ff @(posedge clk) begin
    if (fill_step && (fill_cnt == word_sel)) begin
      fill_word <= mem_rsp.rdata;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      IDLE: begin
        if (core_req.req) begin
          state_nx = CHECK;
        end
      end
      CHECK: begin
        if (core_req.write) begin
          state_nx = WRITE;
        end else if (hit) begin
          state_nx = IDLE;
        end else begin
          state_nx = FILL;
        end
      end
      FILL: begin
        if (fill_step && (fill_cnt == '1)) begin
          state_nx = DELIVER;
        end
      end
      DELIVER: state_nx = IDLE;
      WRITE: begin
        if (!mem_rsp.stall) begin
          state_nx = IDLE;
        end
      end
      default: state_nx = IDLE;
    endcase
  end

  // ====================
  // outputs and array writes
  // ====================
  always_comb begin
    core_rsp   = '0;
    mem_req    = '0;
    tag_we     = 1'b0;
    da_byte_we = '0;
    // refill word in every lane, the enables pick one
    da_wdata   = {LINE_WORDS{mem_rsp.rdata}};
    case (state)
      IDLE: begin
        // lookup cycle
        core_rsp.stall = core_req.req;
      end
      CHECK: begin
        core_rsp.stall = core_req.write || !hit;
        core_rsp.rdata = da_rdata[word_sel*`DATA_BITS +: `DATA_BITS];
      end
      FILL: begin
        core_rsp.stall       = 1'b1;
        mem_req.req          = 1'b1;
        mem_req.write        = 1'b0;
        mem_req.addr.f.tag   = core_req.addr.f.tag;
        mem_req.addr.f.index = index;
        mem_req.addr.f.offset = {fill_cnt, 2'b00};
        mem_req.acc_type     = ACC_WORD;
        if (!mem_rsp.stall) begin
          da_byte_we[{fill_cnt, 2'b00} +: 4] = 4'hf;
          // tag goes in with the last word
          tag_we = (fill_cnt == '1);
        end
      end
      DELIVER: begin
        core_rsp.rdata = fill_word;
      end
      WRITE: begin
        // write-through, store goes out unchanged
        mem_req        = mem_req_t'(core_req);
        core_rsp.stall = mem_rsp.stall;
        core_rsp.rdata = mem_rsp.rdata;
        // no allocate, the line is patched only on a hit
        if (!mem_rsp.stall && hit) begin
          da_byte_we[{word_sel, 2'b00} +: 4] =
            byte_mask(core_req.acc_type, core_req.addr.f.offset[1:0]);
          da_wdata = {LINE_WORDS{lane_data(core_req.wdata, core_req.acc_type)}};
        end
      end
      default: ;
    endcase
  end

endmodule

//--- design/mem_arbiter.sv
// Memory bus round-robin arbiter
module mem_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::mem_req_t c_req,
  output cache_pkg::mem_rsp_t c_rsp,
  input  cache_pkg::mem_req_t d_req,
  output cache_pkg::mem_rsp_t d_rsp,
  output cache_pkg::mem_req_t bus_req,
  input  cache_pkg::mem_rsp_t bus_rsp
);
  import cache_pkg::*;

  // transaction open on the bus
  logic busy;
  // granted peer, 0 cache, 1 data port
  logic sel;
  // last served peer
  logic last;
  logic pick_d;

  // data port wins alone or on a tie after a cache turn
  assign pick_d = d_req.req && (!c_req.req || !last);

  // ====================
  // grant register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      sel  <= 1'b0;
      // first tie goes to the cache
      last <= 1'b1;
    end else if (!busy) begin
      if (c_req.req || d_req.req) begin
        busy <= 1'b1;
        sel  <= pick_d;
        last <= pick_d;
      end
    end else if (!bus_rsp.stall) begin
      // done cycle of the granted peer
      busy <= 1'b0;
    end
  end

  // ====================
  // routing
  // ====================
  always_comb begin
    bus_req = '0;
    // anyone not on the bus just waits
    c_rsp.rdata = '0;
    c_rsp.stall = c_req.req;
    d_rsp.rdata = '0;
    d_rsp.stall = d_req.req;
    if (busy) begin
      if (sel) begin
        bus_req = d_req;
        d_rsp   = bus_rsp;
      end else begin
        bus_req = c_req;
        c_rsp   = bus_rsp;
      end
    end
  end

endmodule

//--- design/main_mem.sv
// Behavioral main memory
`include "cache_config.svh"

module main_mem (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::mem_req_t req,
  output cache_pkg::mem_rsp_t rsp
);
  import cache_pkg::*;

  localparam int MEM_ADDR_BITS = $clog2(`MEM_WORDS);
  localparam int LAT_BITS = $clog2(`MEM_LATENCY + 1);

  logic [`DATA_BITS-1:0]    mem [`MEM_WORDS];
  logic [LAT_BITS-1:0]      lat_cnt;
  logic [MEM_ADDR_BITS-1:0] word_addr;
  logic                     done;
  logic [3:0]               wmask;
  logic [`DATA_BITS-1:0]    wlane;

  // word index, upper bits dropped so addresses wrap
  assign word_addr = req.addr.raw[2 +: MEM_ADDR_BITS];
  assign done      = req.req && (lat_cnt == LAT_BITS'(`MEM_LATENCY));
  assign wmask     = byte_mask(req.acc_type, req.addr.raw[1:0]);
  assign wlane     = lane_data(req.wdata, req.acc_type);

  // whole aligned word on reads
  assign rsp.rdata = done ? mem[word_addr] : '0;
  assign rsp.stall = req.req && !done;

  initial begin
    for (int w = 0; w < `MEM_WORDS; w++) begin
      mem[w] = '0;
    end
  end

  // ====================
  // latency counter
  // ====================
  // counts wait cycles of the open request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lat_cnt <= '0;
    end else if (!req.req || done) begin
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  // byte-masked write at the end of the done cycle
  always_ff @(posedge clk) begin
    if (done && req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask[b]) begin
          mem[word_addr][b*8 +: 8] <= wlane[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- design/cache_subsys.sv
// Instruction memory subsystem top
module cache_subsys (
  input  logic                 clk,
  input  logic                 rst_n,
  // instruction port
  input  cache_pkg::core_req_t i_req,
  output cache_pkg::core_rsp_t i_rsp,
  // uncached data port
  input  cache_pkg::core_req_t d_req,
  output cache_pkg::core_rsp_t d_rsp
);
  import cache_pkg::*;

  // ====================
  // internal buses
  // ====================
  // cache refill and store traffic
  mem_req_t c_mem_req;
  mem_rsp_t c_mem_rsp;
  // data port on the memory side
  mem_rsp_t d_mem_rsp;
  // shared memory bus
  mem_req_t bus_req;
  mem_rsp_t bus_rsp;

  assign d_rsp = core_rsp_t'(d_mem_rsp);

  l1c_inst l1c_inst_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .core_req(i_req),
    .core_rsp(i_rsp),
    .mem_req (c_mem_req),
    .mem_rsp (c_mem_rsp)
  );

  // cache is peer 0, data port is peer 1
  mem_arbiter mem_arbiter_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .c_req  (c_mem_req),
    .c_rsp  (c_mem_rsp),
    .d_req  (mem_req_t'(d_req)),
    .d_rsp  (d_mem_rsp),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp)
  );

  main_mem main_mem_i (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (bus_req),
    .rsp  (bus_rsp)
  );

endmodule

//--- tb/cache_subsys_assert.sv
// Cache subsystem protocol checks
`include "cache_config.svh"

module cache_subsys_assert (
  input logic                 clk,
  input logic                 rst_n,
  input cache_pkg::core_req_t i_req,
  input cache_pkg::core_rsp_t i_rsp,
  input cache_pkg::core_req_t d_req,
  input cache_pkg::core_rsp_t d_rsp,
  input cache_pkg::mem_req_t  c_mem_req,
  input cache_pkg::mem_rsp_t  c_mem_rsp,
  input cache_pkg::mem_req_t  bus_req,
  input cache_pkg::mem_rsp_t  bus_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  // ====================
  // arbitration
  // ====================
  // both peers done in one cycle means both were routed
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(c_mem_req.req && !c_mem_rsp.stall && d_req.req && !d_rsp.stall))
    else $error("both peers completed on the bus in one cycle");

  // ====================
  // handshake
  // ====================
  a_i_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (i_req.req && i_rsp.stall) |=> $stable(i_req))
    else $error("i_req changed while stalled");
  a_d_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (d_req.req && d_rsp.stall) |=> $stable(d_req))
    else $error("d_req changed while stalled");
  a_c_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (c_mem_req.req && c_mem_rsp.stall) |=> $stable(c_mem_req))
    else $error("c_mem_req changed while stalled");

  // wait only with a request
  a_wait_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!i_rsp.stall || i_req.req) && (!d_rsp.stall || d_req.req) &&
    (!c_mem_rsp.stall || c_mem_req.req) && (!bus_rsp.stall || bus_req.req))
    else $error("wait high without a request");

  // memory done after exactly MEM_LATENCY wait cycles
  a_mem_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req.req && !bus_rsp.stall) |->
      ($past(bus_rsp.stall, 1) && $past(bus_rsp.stall, 2) &&
       $past(bus_rsp.stall, `MEM_LATENCY) &&
       !$past(bus_rsp.stall, `MEM_LATENCY + 1)))
    else $error("memory done cycle off its latency");

endmodule

bind cache_subsys cache_subsys_assert cache_subsys_assert_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .i_req    (i_req),
  .i_rsp    (i_rsp),
  .d_req    (d_req),
  .d_rsp    (d_rsp),
  .c_mem_req(c_mem_req),
  .c_mem_rsp(c_mem_rsp),
  .bus_req  (bus_req),
  .bus_rsp  (bus_rsp)
);

//--- tb/tb_cache_subsys.sv
// Cache subsystem testbench
`include "cache_config.svh"

module tb_cache_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic      clk;
  logic      rst_n;
  core_req_t i_req;
  core_rsp_t i_rsp;
  core_req_t d_req;
  core_rsp_t d_rsp;

  int errors;
  int timeouts;

  // one queue per testdata column
  byte         q_port[$];
  byte         q_op[$];
  logic [31:0] q_addr[$];
  int          q_type[$];
  logic [31:0] q_wdata[$];
  logic [31:0] q_exp[$];
  int          q_flags[$];

  cache_subsys cache_subsys_i (
    .clk  (clk),
    .rst_n(rst_n),
    .i_req(i_req),
    .i_rsp(i_rsp),
    .d_req(d_req),
    .d_rsp(d_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // compare tasks
  // ====================
  task automatic check_rsp(input string name, input core_rsp_t exp, input core_rsp_t got);
    if (got.rdata !== exp.rdata) begin
      errors++;
      $display("error t=%0t %s.rdata exp %h got %h", $time, name, exp.rdata, got.rdata);
    end
  endtask

  // tag/index/offset view of the driven address
  task automatic check_addr(input cache_addr_u exp, input cache_addr_u got);
    if (got.f !== exp.f) begin
      errors++;
      $display("error t=%0t addr.f exp %h/%h/%h got %h/%h/%h", $time,
               exp.f.tag, exp.f.index, exp.f.offset, got.f.tag, got.f.index, got.f.offset);
    end
  endtask

  // ====================
  // one operation on one port
  // ====================
  task automatic run_op(input bit on_d, input bit wr, input logic [31:0] addr,
                        input int typ, input logic [31:0] wdata,
                        input logic [31:0] exp, input bit want_hit);
    core_req_t   rq;
    core_rsp_t   rs;
    core_rsp_t   exp_rsp;
    cache_addr_u exp_addr;
    int          cycles;
    bit          done;
    string       name;
    rq = '0;
    rq.req = 1'b1;
    rq.write = wr;
    rq.addr.raw = addr;
    rq.wdata = wdata;
    rq.acc_type = access_type_e'(typ[1:0]);
    // fields from the line geometry
    exp_addr.raw = '0;
    exp_addr.f.tag = addr[31 -: `CACHE_TAG_BITS];
    exp_addr.f.index = addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    exp_addr.f.offset = addr[0 +: `CACHE_OFFSET_BITS];
    check_addr(exp_addr, rq.addr);
    name = on_d ? "d_rsp" : "i_rsp";
    @(negedge clk);
    if (on_d) d_req = rq;
    else i_req = rq;
    cycles = 0;
    done = 1'b0;
    // sample between the drive edge and the next rising edge
    while (!done && cycles < TIMEOUT_CYCLES) begin
      #5;
      cycles++;
      rs = on_d ? d_rsp : i_rsp;
      if (!rs.stall) begin
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (!done) begin
      timeouts++;
      $display("timeout: no done cycle on %s for address %h at %0t", name, addr, $time);
    end else begin
      if (!wr) begin
        exp_rsp.rdata = exp;
        exp_rsp.stall = 1'b0;
        check_rsp(name, exp_rsp, rs);
      end
      // hit is a lookup cycle plus a compare cycle
      if (want_hit && cycles != 2) begin
        errors++;
        $display("error t=%0t %s.latency exp 2 got %0d", $time, name, cycles);
      end
    end
    @(negedge clk);
    if (on_d) d_req = '0;
    else i_req = '0;
  endtask

  task automatic run_line(input int k);
    run_op(q_port[k] == "D", q_op[k] == "W", q_addr[k], q_type[k], q_wdata[k], q_exp[k],
           q_flags[k][1]);
  endtask

  task automatic load_testdata(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         port;
    byte         op;
    logic [31:0] addr;
    int          typ;
    logic [31:0] wdata;
    logic [31:0] exp;
    int          flags;
    ok = 1'b0;
    fd = $fopen("tb/cache_subsys_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the testdata file");
      return;
    end
    while ($fgets(line, fd) > 0) begin
      // comment and blank lines
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %c %h %d %h %h %d", port, op, addr, typ, wdata, exp, flags);
      if (n == 7) begin
        q_port.push_back(port);
        q_op.push_back(op);
        q_addr.push_back(addr);
        q_type.push_back(typ);
        q_wdata.push_back(wdata);
        q_exp.push_back(exp);
        q_flags.push_back(flags);
      end
    end
    $fclose(fd);
    ok = (q_port.size() > 0);
    if (!ok) $display("testdata file holds no operations");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int  i;
    bit  pair;
    bit  ok;
    errors = 0;
    timeouts = 0;
    rst_n = 1'b0;
    i_req = '0;
    d_req = '0;
    void'($urandom(32'hfff4));
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    #5;
    if (i_rsp.stall !== 1'b0 || d_rsp.stall !== 1'b0) begin
      errors++;
      $display("error t=%0t rsp.stall exp 0 got %b/%b", $time, i_rsp.stall, d_rsp.stall);
    end
    load_testdata(ok);
    if (!ok) errors++;
    i = 0;
    while (i < q_port.size()) begin
      // pairable line may run beside the next one on the other port
      pair = q_flags[i][0] && (i + 1 < q_port.size()) && (q_port[i] != q_port[i+1]) &&
             ($urandom_range(1, 0) == 1);
      if (pair) begin
        fork
          run_line(i);
          run_line(i + 1);
        join
        i += 2;
      end else begin
        run_line(i);
        i++;
      end
      repeat ($urandom_range(2, 0)) @(negedge clk);
    end
    $display("errors=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tb/cache_subsys_testdata.txt
# port op addr type wdata expect flags
# type 0 byte 1 half 2 word; flags bit0 may pair with next line, bit1 expect a 2-cycle hit
I R 00000000 2 00000000 00000000 0
I R 00000004 2 00000000 00000000 2
D W 00000100 2 11223344 00000000 0
D W 00000104 2 55667788 00000000 0
I R 00000100 2 00000000 11223344 0
I R 00000104 2 00000000 55667788 2
I R 00000100 2 00000000 11223344 2
I W 00000101 0 000000ab 00000000 0
I R 00000100 2 00000000 1122ab44 2
I W 00000106 1 0000beef 00000000 0
I R 00000104 2 00000000 beef7788 2
D R 00000104 2 00000000 beef7788 0
D R 00001100 2 00000000 1122ab44 0
I W 00000200 2 cafe0001 00000000 0
I R 00000200 2 00000000 cafe0001 0
I R 00000000 2 00000000 00000000 0
I R 00000200 2 00000000 cafe0001 0
I R 00000000 2 00000000 00000000 0
D W 00000008 2 dead0008 00000000 0
I R 00000008 2 00000000 00000000 2
I R 00000208 2 00000000 00000000 0
I R 00000008 2 00000000 dead0008 0
I R 00000300 2 00000000 00000000 1
D W 00000400 2 0a0b0c0d 00000000 0
I R 00000504 2 00000000 00000000 1
D R 00000400 2 00000000 0a0b0c0d 0
I R 00000600 2 00000000 00000000 1
D W 00000700 2 12345678 00000000 0
D R 00000700 2 00000000 12345678 0
I R 00000604 2 00000000 00000000 2

//--- cache_subsys.f
+incdir+design
design/cache_pkg.sv
design/tag_array.sv
design/data_array.sv
design/l1c_inst.sv
design/mem_arbiter.sv
design/main_mem.sv
design/cache_subsys.sv
tb/cache_subsys_assert.sv
tb/tb_cache_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache subsystem simulation

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cache_subsys.f \
  --top-module tb_cache_subsys -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cache_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
